// File: include/packer_cfg.svh
// Word, length and fill widths, queue depth and scheduler drain time
`ifndef PACKER_CFG_SVH
`define PACKER_CFG_SVH

// --------------------
// Data path widths
// --------------------
`define PK_WORD_W 32 // Code and output word
`define PK_LEN_W 6 // Code length, 1 to 32
`define PK_FILL_W 5 // Pending bits, 0 to 31

// --------------------
// Queues and control
// --------------------
`define PK_QUEUE_DEPTH 16

// Pipeline drain after the last Cr read
`define PK_DRAIN_CYCLES 3

`endif

// File: logic/packer_pkg.sv
// Shared word, length and fill types, component and scheduler state enums
package packer_pkg;

	`include "packer_cfg.svh"

	typedef logic [`PK_WORD_W-1:0] word_t;
	typedef logic [`PK_LEN_W-1:0] len_t;
	typedef logic [`PK_FILL_W-1:0] fill_t;

	// Component being drained
	typedef enum logic [1:0] {
		COMP_Y,
		COMP_CB,
		COMP_CR
	} comp_e;

	typedef enum logic [2:0] {
		IDLE,
		DRAIN_Y,
		DRAIN_CB,
		DRAIN_CR,
		FLUSH
	} sched_state_e;

endpackage

// File: logic/component_queue.sv
// Circular code word queue with registered read data and valid strobe
`timescale 1ns/1ps
`include "packer_cfg.svh"

module component_queue #(
	parameter int DEPTH = `PK_QUEUE_DEPTH
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                write,
	input  packer_pkg::word_t   write_code,
	input  packer_pkg::len_t    write_len,
	input  logic                read,
	output packer_pkg::word_t   read_code,
	output packer_pkg::len_t    read_len,
	output logic                read_valid,
	output logic                empty
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	packer_pkg::word_t code_mem [DEPTH];
	packer_pkg::len_t len_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));

	// Storage
	always_ff @(posedge clk)
	begin
		if (write)
		begin
			code_mem[wr_ptr] <= write_code;
			len_mem[wr_ptr] <= write_len;
		end
		if (read)
		begin
			read_code <= code_mem[rd_ptr];
			read_len <= len_mem[rd_ptr];
		end
	end

	// Pointers and fill level
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			read_valid <= 1'b0;
		end
		else
		begin
			read_valid <= read;
			if (write)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (read)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({write, read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) write |-> !full)
		else $error("write to a full queue");
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) read |-> !empty)
		else $error("read from an empty queue");

endmodule

// File: logic/block_scheduler.sv
// Block FSM draining the Y, Cb and Cr queues in order, busy level
`timescale 1ns/1ps
`include "packer_cfg.svh"

module block_scheduler (
	input  logic clk,
	input  logic rst,
	input  logic eob,
	input  logic y_empty,
	input  logic cb_empty,
	input  logic cr_empty,
	output logic y_read,
	output logic cb_read,
	output logic cr_read,
	output logic busy
);

	localparam int CNT_W = $clog2(`PK_DRAIN_CYCLES + 1);

	packer_pkg::sched_state_e state;
	packer_pkg::sched_state_e state_next;
	packer_pkg::comp_e active;
	logic draining;
	logic [CNT_W-1:0] flush_cnt;

	// --------------------
	// Component decode
	// --------------------
	always_comb
	begin
		draining = 1'b1;
		case (state)
			packer_pkg::DRAIN_Y: active = packer_pkg::COMP_Y;
			packer_pkg::DRAIN_CB: active = packer_pkg::COMP_CB;
			packer_pkg::DRAIN_CR: active = packer_pkg::COMP_CR;
			default:
			begin
				active = packer_pkg::COMP_Y;
				draining = 1'b0;
			end
		endcase
	end

	// One read per cycle, only to the active queue
	assign y_read = draining && (active == packer_pkg::COMP_Y) && !y_empty;
	assign cb_read = draining && (active == packer_pkg::COMP_CB) && !cb_empty;
	assign cr_read = draining && (active == packer_pkg::COMP_CR) && !cr_empty;

	assign busy = (state != packer_pkg::IDLE);

	// --------------------
	// Next state
	// --------------------
	always_comb
	begin
		state_next = state;
		case (state)
			packer_pkg::IDLE:
				if (eob)
					state_next = packer_pkg::DRAIN_Y;
			packer_pkg::DRAIN_Y:
				if (y_empty)
					state_next = packer_pkg::DRAIN_CB;
			packer_pkg::DRAIN_CB:
				if (cb_empty)
					state_next = packer_pkg::DRAIN_CR;
			packer_pkg::DRAIN_CR:
				if (cr_empty)
					state_next = packer_pkg::FLUSH;
			packer_pkg::FLUSH:
				if (flush_cnt == CNT_W'(`PK_DRAIN_CYCLES - 1))
					state_next = packer_pkg::IDLE;
			default:
				state_next = packer_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= packer_pkg::IDLE;
			flush_cnt <= '0;
		end
		else
		begin
			state <= state_next;
			if (state == packer_pkg::FLUSH)
				flush_cnt <= flush_cnt + 1'b1; // Aligner and assembler settle
			else
				flush_cnt <= '0;
		end
	end

	a_eob_idle: assert property (@(posedge clk) disable iff (rst) busy |-> !eob)
		else $error("eob while busy");

endmodule

// File: logic/bit_aligner.sv
// Code masking, placement at the fill offset and fill tracking
`timescale 1ns/1ps
`include "packer_cfg.svh"

module bit_aligner (
	input  logic                clk,
	input  logic                rst,
	input  packer_pkg::word_t   y_code,
	input  packer_pkg::word_t   cb_code,
	input  packer_pkg::word_t   cr_code,
	input  packer_pkg::len_t    y_len,
	input  packer_pkg::len_t    cb_len,
	input  packer_pkg::len_t    cr_len,
	input  logic                y_valid,
	input  logic                cb_valid,
	input  logic                cr_valid,
	output packer_pkg::word_t   aligned_hi,
	output packer_pkg::word_t   aligned_lo,
	output logic                aligned_valid,
	output logic                word_done,
	output packer_pkg::fill_t   orc
);

	packer_pkg::word_t code;
	packer_pkg::word_t mask;
	packer_pkg::len_t len;
	packer_pkg::len_t sum;
	logic [2*`PK_WORD_W-1:0] placed;
	logic valid;

	// Valids are exclusive, so OR the gated inputs
	assign valid = y_valid | cb_valid | cr_valid;
	assign code = ({`PK_WORD_W{y_valid}} & y_code) | ({`PK_WORD_W{cb_valid}} & cb_code)
		| ({`PK_WORD_W{cr_valid}} & cr_code);
	assign len = ({`PK_LEN_W{y_valid}} & y_len) | ({`PK_LEN_W{cb_valid}} & cb_len)
		| ({`PK_LEN_W{cr_valid}} & cr_len);

	assign mask = ~({`PK_WORD_W{1'b1}} >> len); // Top len bits
	assign placed = {code & mask, {`PK_WORD_W{1'b0}}} >> orc;
	assign sum = len + {1'b0, orc};

	always_ff @(posedge clk)
	begin
		if (valid)
		begin
			aligned_hi <= placed[2*`PK_WORD_W-1:`PK_WORD_W];
			aligned_lo <= placed[`PK_WORD_W-1:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			aligned_valid <= 1'b0;
			word_done <= 1'b0;
			orc <= '0;
		end
		else
		begin
			aligned_valid <= valid;
			word_done <= valid && (sum >= `PK_LEN_W'(`PK_WORD_W));
			if (valid)
				orc <= sum[`PK_FILL_W-1:0]; // mod 32
		end
	end

	a_len_range: assert property (@(posedge clk) disable iff (rst)
		valid |-> (len >= 1 && len <= `PK_LEN_W'(`PK_WORD_W)))
		else $error("code length out of range");
	a_one_valid: assert property (@(posedge clk) disable iff (rst)
		$onehot0({y_valid, cb_valid, cr_valid}))
		else $error("more than one component valid");

endmodule

// File: logic/word_assembler.sv
// Accumulator merging aligned bits into output words with data_ready
`timescale 1ns/1ps

module word_assembler (
	input  logic                clk,
	input  logic                rst,
	input  packer_pkg::word_t   aligned_hi,
	input  packer_pkg::word_t   aligned_lo,
	input  logic                aligned_valid,
	input  logic                word_done,
	output packer_pkg::word_t   jpeg_bitstream,
	output logic                data_ready
);

	packer_pkg::word_t acc; // Pending bits, MSB aligned

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc <= '0;
			jpeg_bitstream <= '0;
			data_ready <= 1'b0;
		end
		else
		begin
			data_ready <= aligned_valid && word_done;
			if (aligned_valid && word_done)
			begin
				jpeg_bitstream <= acc | aligned_hi;
				acc <= aligned_lo; // Spill into next word
			end
			else if (aligned_valid)
				acc <= acc | aligned_hi;
		end
	end

endmodule

// File: logic/stream_merge_top.sv
// Stream merger top: three component queues, scheduler, aligner, assembler
`timescale 1ns/1ps

module stream_merge_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                y_write,
	input  packer_pkg::word_t   y_code,
	input  packer_pkg::len_t    y_len,
	input  logic                cb_write,
	input  packer_pkg::word_t   cb_code,
	input  packer_pkg::len_t    cb_len,
	input  logic                cr_write,
	input  packer_pkg::word_t   cr_code,
	input  packer_pkg::len_t    cr_len,
	input  logic                eob,
	output packer_pkg::word_t   jpeg_bitstream,
	output logic                data_ready,
	output packer_pkg::fill_t   orc,
	output logic                busy
);

	logic y_read, cb_read, cr_read;
	logic y_empty, cb_empty, cr_empty;
	logic y_valid, cb_valid, cr_valid;
	packer_pkg::word_t y_rd_code, cb_rd_code, cr_rd_code;
	packer_pkg::len_t y_rd_len, cb_rd_len, cr_rd_len;
	packer_pkg::word_t aligned_hi, aligned_lo;
	logic aligned_valid;
	logic word_done;

	// --------------------
	// Component queues
	// --------------------
	component_queue u_y_queue (
		.clk(clk), .rst(rst),
		.write(y_write), .write_code(y_code), .write_len(y_len),
		.read(y_read), .read_code(y_rd_code), .read_len(y_rd_len),
		.read_valid(y_valid), .empty(y_empty)
	);

	component_queue u_cb_queue (
		.clk(clk), .rst(rst),
		.write(cb_write), .write_code(cb_code), .write_len(cb_len),
		.read(cb_read), .read_code(cb_rd_code), .read_len(cb_rd_len),
		.read_valid(cb_valid), .empty(cb_empty)
	);

	component_queue u_cr_queue (
		.clk(clk), .rst(rst),
		.write(cr_write), .write_code(cr_code), .write_len(cr_len),
		.read(cr_read), .read_code(cr_rd_code), .read_len(cr_rd_len),
		.read_valid(cr_valid), .empty(cr_empty)
	);

	block_scheduler u_scheduler (
		.clk(clk), .rst(rst), .eob(eob),
		.y_empty(y_empty), .cb_empty(cb_empty), .cr_empty(cr_empty),
		.y_read(y_read), .cb_read(cb_read), .cr_read(cr_read),
		.busy(busy)
	);

	// --------------------
	// Packer pipeline
	// --------------------
	bit_aligner u_aligner (
		.clk(clk), .rst(rst),
		.y_code(y_rd_code), .cb_code(cb_rd_code), .cr_code(cr_rd_code),
		.y_len(y_rd_len), .cb_len(cb_rd_len), .cr_len(cr_rd_len),
		.y_valid(y_valid), .cb_valid(cb_valid), .cr_valid(cr_valid),
		.aligned_hi(aligned_hi), .aligned_lo(aligned_lo),
		.aligned_valid(aligned_valid), .word_done(word_done), .orc(orc)
	);

	word_assembler u_assembler (
		.clk(clk), .rst(rst),
		.aligned_hi(aligned_hi), .aligned_lo(aligned_lo),
		.aligned_valid(aligned_valid), .word_done(word_done),
		.jpeg_bitstream(jpeg_bitstream), .data_ready(data_ready)
	);

endmodule

// File: tests/merge_tests.svh
// Directed tests: reset state, full codes, component order, boundary, random and empty blocks
`ifndef MERGE_TESTS_SVH
`define MERGE_TESTS_SVH

task automatic test_reset_state();
	int errs;
	errs = error_count;
	@(negedge clk);
	check_flag(busy, 1'b0, "busy after reset");
	check_flag(data_ready, 1'b0, "data_ready after reset");
	check_fill(orc, '0, "orc after reset");
	check_word(jpeg_bitstream, '0, "jpeg_bitstream after reset");
	finish_test("test 1 reset state", errs);
endtask

task automatic test_full_length();
	int errs;
	int words_before;
	errs = error_count;
	words_before = words_seen;
	write_comp(packer_pkg::COMP_Y, 32'hDEADBEEF, 6'd32);
	write_comp(packer_pkg::COMP_Y, 32'h01234567, 6'd32);
	send_block();
	check_count(words_seen - words_before, 2, "words from two full codes");
	check_word(last_word, 32'h01234567, "second full code");
	check_fill(orc, '0, "orc after full codes");
	finish_test("test 2 full-length codes", errs);
endtask

task automatic test_component_order();
	int errs;
	errs = error_count;
	// Low bits of each code are junk
	write_comp(packer_pkg::COMP_CR, 32'hA5FFFFFF, 6'd8);
	write_comp(packer_pkg::COMP_CB, 32'h3C123456, 6'd8);
	write_comp(packer_pkg::COMP_Y, 32'hF0ABCDEF, 6'd16);
	send_block();
	check_word(last_word, 32'hF0AB3CA5, "Y, Cb, Cr word");
	check_fill(orc, '0, "orc after ordered block");
	finish_test("test 3 component order", errs);
endtask

task automatic test_word_boundary();
	int errs;
	int words_before;
	errs = error_count;
	words_before = words_seen;
	write_comp(packer_pkg::COMP_Y, 32'hABC00000, 6'd12);
	write_comp(packer_pkg::COMP_Y, 32'h12300000, 6'd12);
	write_comp(packer_pkg::COMP_Y, 32'h45600000, 6'd12);
	send_block();
	check_count(words_seen - words_before, 1, "words from 36 bits");
	check_word(last_word, 32'hABC12345, "word across boundary");
	check_fill(orc, 5'd4, "orc with 4 pending bits");
	// Next block picks up the pending nibble
	write_comp(packer_pkg::COMP_Y, 32'h789ABCD0, 6'd28);
	send_block();
	check_word(last_word, 32'h6789ABCD, "word continuing pending bits");
	check_fill(orc, '0, "orc after continuation");
	finish_test("test 4 word boundary", errs);
endtask

task automatic test_random_blocks();
	int errs;
	int n;
	packer_pkg::word_t code;
	packer_pkg::len_t len;
	errs = error_count;
	for (int blk = 0; blk < 5; blk++)
	begin
		for (int c = 0; c < 3; c++)
		begin
			n = int'(rand_bits(3));
			for (int k = 0; k < n; k++)
			begin
				code = rand_bits(32);
				len = packer_pkg::len_t'(rand_bits(5) + 1);
				write_comp(packer_pkg::comp_e'(c), code, len);
			end
		end
		send_block();
		check_fill(orc, packer_pkg::fill_t'(total_bits % 32), "orc after random block");
	end
	check_count(ref_bits.size(), total_bits % 32, "model bits left over");
	finish_test("test 5 random blocks", errs);
endtask

task automatic test_empty_block();
	int errs;
	int words_before;
	errs = error_count;
	words_before = words_seen;
	send_block(); // Also waits for busy to rise
	check_count(words_seen - words_before, 0, "words from empty block");
	check_fill(orc, packer_pkg::fill_t'(total_bits % 32), "orc after empty block");
	finish_test("test 6 empty block", errs);
endtask

`endif

// File: tests/merge_tb.sv
// Testbench top: clock, reset, DUT, LFSR, bit stream model, compare tasks and wait tasks
`timescale 1ns/1ps
`include "packer_cfg.svh"

module merge_tb;

	logic clk;
	logic rst;
	logic y_write, cb_write, cr_write;
	packer_pkg::word_t y_code, cb_code, cr_code;
	packer_pkg::len_t y_len, cb_len, cr_len;
	logic eob;
	packer_pkg::word_t jpeg_bitstream;
	logic data_ready;
	packer_pkg::fill_t orc;
	logic busy;

	logic [31:0] lfsr_state = 32'h0261b62c;
	bit y_bits[$]; // Bits of the block being written
	bit cb_bits[$];
	bit cr_bits[$];
	bit ref_bits[$]; // Merged stream still to come out
	int total_bits = 0;
	int words_seen = 0;
	packer_pkg::word_t last_word = '0;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;

	stream_merge_top dut (
		.clk(clk), .rst(rst),
		.y_write(y_write), .y_code(y_code), .y_len(y_len),
		.cb_write(cb_write), .cb_code(cb_code), .cb_len(cb_len),
		.cr_write(cr_write), .cr_code(cr_code), .cr_len(cr_len),
		.eob(eob),
		.jpeg_bitstream(jpeg_bitstream), .data_ready(data_ready),
		.orc(orc), .busy(busy)
	);

	initial
		clk = 1'b0;
	always #50 clk = ~clk;

	// --------------------
	// Random source
	// --------------------
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]; // x^32+x^22+x^2+x+1
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], lfsr_step()};
		return r;
	endfunction

	// --------------------
	// Compare tasks
	// --------------------
	task automatic check_word(input packer_pkg::word_t got, input packer_pkg::word_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic check_fill(input packer_pkg::fill_t got, input packer_pkg::fill_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
		begin
			$display("MISMATCH at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
			error_count++;
		end
	endtask

	// Every finished word against the model
	always @(negedge clk)
	begin : word_monitor
		packer_pkg::word_t exp_word;
		if (!rst && data_ready === 1'b1)
		begin
			words_seen++;
			last_word = jpeg_bitstream;
			if (ref_bits.size() < `PK_WORD_W)
			begin
				$display("Error at %0t ns: data_ready without a full expected word", $time);
				error_count++;
			end
			else
			begin
				exp_word = '0;
				for (int i = 0; i < `PK_WORD_W; i++)
					exp_word = {exp_word[`PK_WORD_W-2:0], ref_bits.pop_front()};
				check_word(jpeg_bitstream, exp_word, "output word");
			end
		end
	end

	// --------------------
	// Drive and wait
	// --------------------
	task automatic write_comp(input packer_pkg::comp_e comp, input packer_pkg::word_t code,
		input packer_pkg::len_t len);
		@(posedge clk);
		for (int i = 0; i < int'(len); i++)
		begin
			case (comp)
				packer_pkg::COMP_Y: y_bits.push_back(code[`PK_WORD_W-1-i]);
				packer_pkg::COMP_CB: cb_bits.push_back(code[`PK_WORD_W-1-i]);
				default: cr_bits.push_back(code[`PK_WORD_W-1-i]);
			endcase
		end
		case (comp)
			packer_pkg::COMP_Y:
			begin
				y_write <= 1'b1;
				y_code <= code;
				y_len <= len;
			end
			packer_pkg::COMP_CB:
			begin
				cb_write <= 1'b1;
				cb_code <= code;
				cb_len <= len;
			end
			default:
			begin
				cr_write <= 1'b1;
				cr_code <= code;
				cr_len <= len;
			end
		endcase
		@(posedge clk);
		y_write <= 1'b0;
		cb_write <= 1'b0;
		cr_write <= 1'b0;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (busy !== level && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (busy !== level)
		begin
			$display("Timeout at %0t ns: busy never went to %b", $time, level);
			$display("SOME TESTS FAILED");
			$finish;
		end
	endtask

	// Block order is Y, Cb, Cr whatever the write order was
	task automatic send_block();
		total_bits += y_bits.size() + cb_bits.size() + cr_bits.size();
		while (y_bits.size() > 0)
			ref_bits.push_back(y_bits.pop_front());
		while (cb_bits.size() > 0)
			ref_bits.push_back(cb_bits.pop_front());
		while (cr_bits.size() > 0)
			ref_bits.push_back(cr_bits.pop_front());
		@(posedge clk);
		eob <= 1'b1;
		@(posedge clk);
		eob <= 1'b0;
		wait_busy(1'b1, 4);
		wait_busy(1'b0, 200);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count != errors_before)
		begin
			tests_failed++;
			$display("%s: failed", name);
		end
		else
			$display("%s: ok", name);
	endtask

	`include "merge_tests.svh"

	initial
	begin
		rst = 1'b1;
		eob = 1'b0;
		y_write = 1'b0;
		cb_write = 1'b0;
		cr_write = 1'b0;
		y_code = '0;
		cb_code = '0;
		cr_code = '0;
		y_len = '0;
		cb_len = '0;
		cr_len = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		test_reset_state();
		test_full_length();
		test_component_order();
		test_word_boundary();
		test_random_blocks();
		test_empty_block();

		repeat (4) @(posedge clk);
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: src.f
+incdir+include
+incdir+tests
logic/packer_pkg.sv
logic/component_queue.sv
logic/block_scheduler.sv
logic/bit_aligner.sv
logic/word_assembler.sv
logic/stream_merge_top.sv
tests/merge_tb.sv

// File: Bender.yml
package:
  name: stream_merge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/packer_pkg.sv
      - logic/component_queue.sv
      - logic/block_scheduler.sv
      - logic/bit_aligner.sv
      - logic/word_assembler.sv
      - logic/stream_merge_top.sv
  - target: test
    include_dirs:
      - include
      - tests
    files:
      - tests/merge_tb.sv
